// File: block_align_130b.f
+incdir+test
logic/pcie_line_pkg.sv
logic/aligner_pkg.sv
logic/align_links.sv
logic/sync_search.sv
logic/block_tracker.sv
logic/block_extract.sv
logic/block_align_130b.sv
test/block_align_130b_tb.sv

// File: logic/align_links.sv
// ------------------------------
// links between the three stages of the block aligner
// search_if carries the history window and the search result
// track_if carries the lock position and the word qualifiers
// ------------------------------
`timescale 1ns/100ps

interface search_if;

  // current word on top, two registered words below
  logic [aligner_pkg::window_w-1:0] window;

  // exactly one offset matched the alignment pattern
  logic                             hit;
  logic [aligner_pkg::offset_w-1:0] hit_offset;

  // follows enable
  logic                             live;

  modport source (
    output window,
    output hit,
    output hit_offset,
    output live
  );

  modport tracker (
    input hit,
    input hit_offset,
    input live
  );

  modport reader (
    input window
  );

endinterface

interface track_if;

  // bit offset of the header in the window for this cycle
  logic [aligner_pkg::offset_w-1:0] offset;
  logic                             word_valid;
  logic                             payload_valid;
  logic                             block_start;

  modport source (
    output offset,
    output word_valid,
    output payload_valid,
    output block_start
  );

  modport reader (
    input offset,
    input word_valid,
    input payload_valid,
    input block_start
  );

endinterface

// File: logic/aligner_pkg.sv
// ------------------------------
// structural constants of the 16-bit block aligner
// and the state type of its lock tracker
// ------------------------------
package aligner_pkg;

  // ------------------------------
  // lane geometry
  // ------------------------------

  // width of one lane word
  localparam int data_w = 16;

  // a bit offset within a word needs this many bits
  localparam int offset_w = 4;

  // three words of history, oldest word in the low bits
  localparam int window_w = 48;

  localparam int bytes_per_word = 2;

  // ------------------------------
  // block tracking
  // ------------------------------

  // byte count of the final word of a block
  localparam int last_byte_count = 14;

  // the 2-bit header of each block moves the payload up by this much
  localparam int offset_step = 2;

  // idle waits for the lane to come up, unaligned searches,
  // aligned delivers words and stall covers the word lost at an offset wrap
  typedef enum logic [1:0] {
    idle,
    unaligned,
    aligned,
    stall
  } align_state_e;

endpackage

// File: logic/block_align_130b.sv
// ------------------------------
// receive block aligner for one 16-bit lane of 128b/130b blocks
// raise blockalign during training to search for the alignment pattern
// aligned words come out in the cycle they are taken in
// ------------------------------
`timescale 1ns/100ps

module block_align_130b (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            enable,
  input  logic                            blockalign,
  input  logic [aligner_pkg::data_w-1:0]  rx_data_in,
  output logic [aligner_pkg::data_w-1:0]  rx_data_out,
  output logic [pcie_line_pkg::hdr_w-1:0] rx_syncheader,
  output logic                            rx_valid,
  output logic                            rx_datavalid,
  output logic                            rx_startblock,
  output logic                            bad_syncheader,
  output logic                            locked
);

  search_if srch_link ();
  track_if  trk_link ();

  // ------------------------------
  // search, track, extract
  // ------------------------------
  sync_search u_search (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .blockalign (blockalign),
    .rx_data_in (rx_data_in),
    .srch       (srch_link)
  );

  block_tracker u_tracker (
    .clk   (clk),
    .reset (reset),
    .srch  (srch_link),
    .trk   (trk_link)
  );

  block_extract u_extract (
    .srch           (srch_link),
    .trk            (trk_link),
    .rx_data_out    (rx_data_out),
    .rx_syncheader  (rx_syncheader),
    .rx_valid       (rx_valid),
    .rx_datavalid   (rx_datavalid),
    .rx_startblock  (rx_startblock),
    .bad_syncheader (bad_syncheader),
    .locked         (locked)
  );

endmodule

// File: logic/block_extract.sv
// ------------------------------
// output stage of the block aligner
// cuts header and payload out of the history window at the tracked
// offset and checks the header of every block start
// ------------------------------
`timescale 1ns/100ps

module block_extract (
  search_if.reader                          srch,
  track_if.reader                           trk,
  output logic [aligner_pkg::data_w-1:0]    rx_data_out,
  output logic [pcie_line_pkg::hdr_w-1:0]   rx_syncheader,
  output logic                              rx_valid,
  output logic                              rx_datavalid,
  output logic                              rx_startblock,
  output logic                              bad_syncheader,
  output logic                              locked
);

  localparam int hdr_w = pcie_line_pkg::hdr_w;
  localparam int sel_w = aligner_pkg::data_w + hdr_w;

  logic [sel_w-1:0] sel;
  logic [hdr_w-1:0] header;
  logic             header_ok;

  // header bits first, then one word of payload
  assign sel    = srch.window[trk.offset +: sel_w];
  assign header = sel[hdr_w-1:0];

  assign rx_syncheader = header;
  assign rx_data_out   = sel[sel_w-1:hdr_w];

  // ------------------------------
  // header check
  // ------------------------------
  assign header_ok = (header == pcie_line_pkg::sync_data_hdr) ||
                     (header == pcie_line_pkg::sync_os_hdr);

  // in the lock cycle the header is part of the matched pattern,
  // which is a legal header, so that word never flags
  assign bad_syncheader = trk.block_start && !header_ok;

  // ------------------------------
  // qualifiers
  // ------------------------------
  assign rx_valid      = trk.word_valid;
  assign rx_datavalid  = trk.payload_valid;
  assign rx_startblock = trk.block_start;
  assign locked        = trk.word_valid;

endmodule

// File: logic/block_tracker.sv
// ------------------------------
// lock state machine of the block aligner
// counts the bytes of each block, moves the header offset after every
// block and inserts one stall word when the offset wraps
// ------------------------------
`timescale 1ns/100ps

module block_tracker (
  input  logic      clk,
  input  logic      reset,
  search_if.tracker srch,
  track_if.source   trk
);

  localparam int count_w = $clog2(pcie_line_pkg::block_payload_bytes);
  localparam int off_w   = aligner_pkg::offset_w;

  aligner_pkg::align_state_e state;
  aligner_pkg::align_state_e state_nxt;

  logic [count_w-1:0] byte_count;
  logic [count_w-1:0] byte_count_nxt;
  logic [off_w-1:0]   offset;
  logic [off_w-1:0]   offset_nxt;
  logic [off_w-1:0]   offset_adv;
  logic               lock;
  logic               realign;
  logic               block_end;

  // first word of a fresh lock, delivered at the hit offset
  assign lock = srch.live && (state == aligner_pkg::unaligned) && srch.hit;

  // a hit anywhere but at the expected block start moves the lane
  assign realign = srch.live && (state == aligner_pkg::aligned) && srch.hit &&
                   ((srch.hit_offset != offset) || (byte_count != '0));

  assign block_end  = (byte_count == count_w'(aligner_pkg::last_byte_count));
  assign offset_adv = offset + off_w'(aligner_pkg::offset_step);

  // ------------------------------
  // next state
  // ------------------------------
  always_comb begin
    state_nxt      = state;
    byte_count_nxt = byte_count;
    offset_nxt     = offset;

    // nothing moves while the lane is disabled
    if (srch.live) begin
      case (state)
        aligner_pkg::idle: begin
          byte_count_nxt = '0;
          state_nxt      = aligner_pkg::unaligned;
        end

        aligner_pkg::unaligned: begin
          if (srch.hit) begin
            offset_nxt     = srch.hit_offset;
            byte_count_nxt = count_w'(aligner_pkg::bytes_per_word);
            state_nxt      = aligner_pkg::aligned;
          end
        end

        aligner_pkg::aligned: begin
          if (realign) begin
            // the hit word already counts as the first of the block
            offset_nxt     = srch.hit_offset;
            byte_count_nxt = count_w'(aligner_pkg::bytes_per_word);
          end else if (block_end) begin
            byte_count_nxt = '0;
            offset_nxt     = offset_adv;
            // after a wrap the next header sits one word further on
            if (offset_adv < offset) begin
              state_nxt = aligner_pkg::stall;
            end
          end else begin
            byte_count_nxt = byte_count + count_w'(aligner_pkg::bytes_per_word);
          end
        end

        aligner_pkg::stall: begin
          state_nxt = aligner_pkg::aligned;
        end

        default: begin
          state_nxt = aligner_pkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= aligner_pkg::idle;
      byte_count <= '0;
      offset     <= '0;
    end else begin
      state      <= state_nxt;
      byte_count <= byte_count_nxt;
      offset     <= offset_nxt;
    end
  end

  // ------------------------------
  // word qualifiers
  // ------------------------------
  assign trk.offset        = lock ? srch.hit_offset : offset;
  assign trk.word_valid    = srch.live && ((state == aligner_pkg::aligned) ||
                                           (state == aligner_pkg::stall) || lock);
  assign trk.payload_valid = srch.live && ((state == aligner_pkg::aligned) || lock);
  assign trk.block_start   = srch.live && (lock || ((state == aligner_pkg::aligned) &&
                                                    (byte_count == '0)));

endmodule

// File: logic/pcie_line_pkg.sv
// ------------------------------
// line coding of 128b/130b blocks as seen on the receive lane
// bits are listed lowest first, which is also the order they arrive in
// used by the search and output stages of the block aligner
// ------------------------------
package pcie_line_pkg;

  // ------------------------------
  // sync header
  // ------------------------------
  localparam int hdr_w = 2;

  // header of a data block
  localparam logic [hdr_w-1:0] sync_data_hdr = 2'b01;

  // header of an ordered-set block
  localparam logic [hdr_w-1:0] sync_os_hdr = 2'b10;

  // payload bytes carried after each header
  localparam int block_payload_bytes = 16;

  // ------------------------------
  // alignment pattern
  // ------------------------------
  localparam int align_payload_w = 32;

  // payload bytes 00 ff 00 ff, first byte in the lowest bits
  localparam logic [align_payload_w-1:0] align_payload = 32'hff00_ff00;

  localparam int align_pattern_w = hdr_w + align_payload_w;

  // header 01 in bits 1:0 followed by the four payload bytes above
  localparam logic [align_pattern_w-1:0] align_pattern = {align_payload, 2'b01};

endpackage

// File: logic/sync_search.sv
// ------------------------------
// input stage of the block aligner
// keeps two past lane words and searches all 16 bit offsets of the
// resulting window for the alignment pattern in the same cycle
// ------------------------------
`timescale 1ns/100ps

module sync_search (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable,
  input  logic                         blockalign,
  input  logic [aligner_pkg::data_w-1:0] rx_data_in,
  search_if.source                     srch
);

  localparam int pat_w = pcie_line_pkg::align_pattern_w;
  localparam int win_w = aligner_pkg::window_w;

  logic [aligner_pkg::data_w-1:0]   word_q1;
  logic [aligner_pkg::data_w-1:0]   word_q2;
  logic [win_w-1:0]                 window;
  logic [aligner_pkg::data_w-1:0]   match;
  logic [aligner_pkg::offset_w-1:0] match_pos;

  // ------------------------------
  // word history
  // ------------------------------

  // a disabled lane flushes its history so that no stale bits
  // can complete a pattern once it comes back
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      word_q1 <= '0;
      word_q2 <= '0;
    end else if (!enable) begin
      word_q1 <= '0;
      word_q2 <= '0;
    end else begin
      word_q1 <= rx_data_in;
      word_q2 <= word_q1;
    end
  end

  assign window = {rx_data_in, word_q1, word_q2};

  // ------------------------------
  // pattern compare per offset
  // ------------------------------
  for (genvar o = 0; o < aligner_pkg::data_w; o++) begin : g_match
    if (o + pat_w <= win_w) begin : g_full
      assign match[o] = (window[o +: pat_w] == pcie_line_pkg::align_pattern);
    end else begin : g_top
      // the top offset runs one bit past the window, the 33 bits that
      // are visible still cannot be produced by a hit at a lower offset
      assign match[o] = (window[win_w-1:o] == pcie_line_pkg::align_pattern[win_w-1-o:0]);
    end
  end

  // encode the matching offset, only meaningful when one bit is set
  always_comb begin
    match_pos = '0;
    for (int i = 0; i < aligner_pkg::data_w; i++) begin
      if (match[i]) begin
        match_pos = aligner_pkg::offset_w'(i);
      end
    end
  end

  assign srch.window     = window;
  assign srch.hit        = blockalign && $onehot(match);
  assign srch.hit_offset = match_pos;
  assign srch.live       = enable;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the block aligner testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  -f block_align_130b.f --top-module block_align_130b_tb -o sim_block_align
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_block_align 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
  exit 0
fi
echo "pass message not found"
exit 1

// File: test/block_stream_tasks.svh
// ------------------------------
// bit-stream model of the lane for the block aligner testbench
// blocks go out header first and lowest bit first, cut into 16-bit words
// included inside the testbench module and works on its signals
// ------------------------------
`ifndef BLOCK_STREAM_TASKS_SVH
`define BLOCK_STREAM_TASKS_SVH

// compare one value and stop the run at the first mismatch
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "value mismatch");
  end
endtask

task automatic push_bits(input logic [31:0] value, input int n);
  for (int i = 0; i < n; i++) begin
    stream_q.push_back(value[i]);
  end
  bits_pushed += n;
endtask

// a block whose header lands at bit p delivers payload word k in the cycle
// in which lane word p/16 + k + 2 is taken
task automatic push_block(input logic [1:0] hdr, input bit align);
  logic [7:0] pay [16];
  int         first;
  for (int i = 0; i < 16; i++) begin
    pay[i] = 8'($urandom);
  end
  if (align) begin
    pay[0] = 8'h00;
    pay[1] = 8'hff;
    pay[2] = 8'h00;
    pay[3] = 8'hff;
  end
  first = int'(bits_pushed / 16) + 2;
  for (int k = 0; k < 8; k++) begin
    exp_data[first + k]  = {pay[2*k+1], pay[2*k]};
    exp_start[first + k] = (k == 0);
    exp_hdr[first + k]   = hdr;
  end
  last_hit = first;
  push_bits(32'(hdr), 2);
  for (int i = 0; i < 16; i++) begin
    push_bits(32'(pay[i]), 8);
  end
endtask

// drive one word, then look at the outputs in the middle of the cycle
task automatic send_word(input logic [15:0] w);
  int c;
  @(posedge clk);
  #0.5;
  enable     = lane_en;
  rx_data_in = w;
  @(negedge clk);
  c = word_idx;
  word_idx++;
  if (!lane_en) begin
    check_value("rx_valid", rx_valid, 0);
    check_value("rx_datavalid", rx_datavalid, 0);
    check_value("rx_startblock", rx_startblock, 0);
    check_value("locked", locked, 0);
    check_value("bad_syncheader", bad_syncheader, 0);
  end else if (c >= check_from && exp_data.exists(c)) begin
    check_value("rx_valid", rx_valid, 1);
    check_value("locked", locked, 1);
    check_value("rx_datavalid", rx_datavalid, 1);
    check_value("rx_data_out", rx_data_out, exp_data[c]);
    check_value("rx_startblock", rx_startblock, exp_start[c]);
    if (exp_start[c]) begin
      check_value("rx_syncheader", rx_syncheader, exp_hdr[c]);
      check_value("bad_syncheader", bad_syncheader,
                  !(exp_hdr[c] == 2'b01 || exp_hdr[c] == 2'b10));
    end else begin
      check_value("bad_syncheader", bad_syncheader, 0);
    end
    payload_seen++;
  end else if (c >= check_from) begin
    check_value("rx_datavalid", rx_datavalid, 0);
    check_value("rx_startblock", rx_startblock, 0);
    check_value("bad_syncheader", bad_syncheader, 0);
    // a locked lane with no payload word is the wrap stall
    if (rx_valid) stall_at.push_back(payload_seen);
  end
endtask

task automatic send_ready_words();
  logic [15:0] w;
  while (stream_q.size() >= 16) begin
    for (int i = 0; i < 16; i++) begin
      w[i] = stream_q.pop_front();
    end
    send_word(w);
  end
endtask

`endif

// File: test/block_align_130b_tb.sv
// ------------------------------
// directed testbench of the 128b/130b block aligner
// runs lock, block rhythm, header check, realignment and disable tests
// ------------------------------
`timescale 1ns/100ps

module block_align_130b_tb;

  // blocks sent over all tests, each takes at most 9 words
  localparam int test_blocks = 40;
  localparam int total_words = 10 + 4 + 6 + test_blocks * 9 + 8;

  logic        clk = 1'b0;
  logic        reset;
  logic        enable;
  logic        blockalign;
  logic [15:0] rx_data_in;
  logic [15:0] rx_data_out;
  logic [1:0]  rx_syncheader;
  logic        rx_valid;
  logic        rx_datavalid;
  logic        rx_startblock;
  logic        bad_syncheader;
  logic        locked;

  // stream model and expected words per cycle
  bit          stream_q[$];
  longint      bits_pushed = 0;
  int          word_idx = 0;
  logic [15:0] exp_data[int];
  bit          exp_start[int];
  logic [1:0]  exp_hdr[int];
  int          check_from = 0;
  int          last_hit = 0;
  bit          lane_en = 1'b0;
  int          payload_seen = 0;
  int          stall_at[$];

  block_align_130b uut (
    .clk            (clk),
    .reset          (reset),
    .enable         (enable),
    .blockalign     (blockalign),
    .rx_data_in     (rx_data_in),
    .rx_data_out    (rx_data_out),
    .rx_syncheader  (rx_syncheader),
    .rx_valid       (rx_valid),
    .rx_datavalid   (rx_datavalid),
    .rx_startblock  (rx_startblock),
    .bad_syncheader (bad_syncheader),
    .locked         (locked)
  );

  always #2 clk = ~clk;

  `include "block_stream_tasks.svh"

  initial begin
    #(total_words * 4 + 200);
    $display("watchdog expired before the test sequence finished");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_state();
    lane_en = 1'b0;
    repeat (4) send_word(16'h0000);
    // the stream starts with the first enabled word
    word_idx = 0;
  endtask

  task automatic lock_and_payload();
    lane_en    = 1'b1;
    check_from = 0;
    push_bits($urandom, $urandom_range(15, 0));
    push_block(2'b01, 1'b1);
    repeat (4) push_block(2'b01, 1'b0);
    send_ready_words();
    check_value("locked", locked, 1);
  endtask

  task automatic block_rhythm();
    payload_seen = 0;
    stall_at.delete();
    repeat (18) push_block(2'b01, 1'b0);
    send_ready_words();
    check_value("stall cycles seen", stall_at.size() >= 2, 1);
    check_value("payload words between stalls", stall_at[1] - stall_at[0], 64);
  endtask

  task automatic bad_header();
    push_block(2'b00, 1'b0);
    push_block(2'b01, 1'b0);
    push_block(2'b11, 1'b0);
    push_block(2'b10, 1'b0);
    repeat (2) push_block(2'b01, 1'b0);
    send_ready_words();
  endtask

  task automatic realign();
    push_bits($urandom, $urandom_range(15, 1));
    push_block(2'b01, 1'b1);
    // the hit word itself still comes out at the old offset
    check_from = last_hit + 1;
    repeat (4) push_block(2'b01, 1'b0);
    send_ready_words();
  endtask

  task automatic disable_lane();
    lane_en = 1'b0;
    repeat (6) push_bits(32'h0, 16);
    send_ready_words();
    lane_en = 1'b1;
    push_bits($urandom, $urandom_range(15, 0));
    // a stale stall can swallow the first hit, so the second one is checked
    push_block(2'b01, 1'b1);
    push_block(2'b01, 1'b1);
    check_from = last_hit + 1;
    repeat (3) push_block(2'b01, 1'b0);
    send_ready_words();
    check_value("locked", locked, 1);
  endtask

  initial begin
    void'($urandom(32'hef46_8128));
    reset      = 1'b1;
    enable     = 1'b0;
    blockalign = 1'b1;
    rx_data_in = 16'h0000;
    repeat (10) @(posedge clk);
    #0.5;
    reset = 1'b0;
    reset_state();
    lock_and_payload();
    block_rhythm();
    bad_header();
    realign();
    disable_lane();
    $display("TEST OK");
    $finish;
  end

endmodule
